// File: rtl/snake_pkg.sv
`default_nettype none

package snake_pkg;

    //////////////////////////////////////////////////////////////////////
    // grid geometry
    //////////////////////////////////////////////////////////////////////

    localparam int COORD_W = 5;  // 32 x 32 grid, wraps for free
    localparam int SCORE_W = 8;  // score counter width, rolls over

    // one grid cell, x in the upper half
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } coord_t;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // opposite directions differ only in bit 1
    typedef enum logic [1:0] {
        DIR_RIGHT = 2'd0,  // x + 1
        DIR_DOWN  = 2'd1,  // y - 1
        DIR_LEFT  = 2'd2,  // x - 1
        DIR_UP    = 2'd3   // y + 1
    } dir_e;

    // what the body register does on a given cycle
    typedef enum logic [1:0] {
        BODY_HOLD  = 2'd0,
        BODY_MOVE  = 2'd1,  // shift, tail drops off
        BODY_GROW  = 2'd2,  // shift, tail kept
        BODY_CLEAR = 2'd3   // back to a single head cell
    } body_cmd_e;

    typedef enum logic [1:0] {
        GAME_IDLE = 2'd0,
        GAME_RUN  = 2'd1,
        GAME_DEAD = 2'd2
    } game_state_e;

    // start conditions
    localparam coord_t INIT_HEAD = '{x: 5'd24, y: 5'd24};
    localparam dir_e   INIT_DIR  = DIR_RIGHT;

endpackage

`default_nettype wire

// File: rtl/snake_steer.sv
`timescale 1ns/1ps
`default_nettype none

module snake_steer import snake_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic dir_strobe,  // new request on dir_req
    input  wire dir_e dir_req,
    input  wire logic advance,     // body moved this cycle
    input  wire logic restart,     // game (re)start
    output dir_e      dir          // pending direction, used by next step
);

    dir_e committed;      // direction of the last real move
    dir_e committed_nxt;  // what committed holds after this edge
    logic reverse;        // request points straight back

    // a request is judged against the direction in force after this edge,
    // so two turns inside one step cannot fold the snake onto itself
    always_comb begin
        committed_nxt = advance ? dir : committed;
        reverse       = (dir_req == dir_e'(committed_nxt ^ 2'b10));
    end

    //////////////////////////////////////////////////////////////////////
    // pending / committed registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            dir       <= INIT_DIR;
            committed <= INIT_DIR;
        end else begin
            if (advance) begin
                committed <= dir;  // step used the pending value
            end
            if (dir_strobe && !reverse) begin
                dir <= dir_req;    // reversal requests just vanish
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/snake_body.sv
`timescale 1ns/1ps
`default_nettype none

module snake_body import snake_pkg::*; #(
    parameter int MAX_LEN = 8  // capacity incl. head
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire body_cmd_e                   cmd,
    input  wire coord_t                      next_head,
    output coord_t [MAX_LEN-1:0]             segs,    // [0] is the head
    output logic   [$clog2(MAX_LEN+1)-1:0]   length   // active segments
);

    localparam int LEN_W    = $clog2(MAX_LEN + 1);
    localparam int SEG_BITS = MAX_LEN * $bits(coord_t);

    // head at INIT_HEAD, every other slot zero
    localparam logic [SEG_BITS-1:0] SEGS_INIT =
        {{((MAX_LEN - 1) * $bits(coord_t)){1'b0}}, INIT_HEAD};

    coord_t [MAX_LEN-1:0] shifted;  // body pushed one slot toward tail
    logic   [LEN_W-1:0]   len_nxt;  // length after this command
    logic                 full;

    //////////////////////////////////////////////////////////////////////
    // shift and mask
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        full    = (length >= LEN_W'(MAX_LEN));
        len_nxt = length;
        // grow at capacity degrades to a plain move
        if (cmd == BODY_GROW && !full) begin
            len_nxt = length + 1'b1;
        end

        shifted[0] = next_head;  // new head enters at slot 0
        for (int i = 1; i < MAX_LEN; i++) begin
            // slots past the new length are zeroed, so the old tail
            // falls off on a move and survives on a grow
            if (i < len_nxt) begin
                shifted[i] = segs[i-1];
            end else begin
                shifted[i] = '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // segment register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            segs   <= SEGS_INIT;
            length <= LEN_W'(1);  // head only
        end else begin
            case (cmd)
                BODY_CLEAR: begin
                    segs   <= SEGS_INIT;
                    length <= LEN_W'(1);
                end
                BODY_MOVE,
                BODY_GROW: begin
                    segs   <= shifted;
                    length <= len_nxt;  // unchanged on move
                end
                default: begin
                    // hold, dead snake stays put
                    segs   <= segs;
                    length <= length;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/snake_referee.sv
`timescale 1ns/1ps
`default_nettype none

module snake_referee import snake_pkg::*; #(
    parameter int MAX_LEN = 8
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          start,
    input  wire logic                          step,
    input  wire logic                          food_load,
    input  wire coord_t                        food_pos,
    input  wire dir_e                          dir,       // pending direction
    input  wire coord_t [MAX_LEN-1:0]          segs,
    input  wire logic [$clog2(MAX_LEN+1)-1:0]  length,
    output body_cmd_e                          cmd,
    output coord_t                             next_head,
    output logic                               advance,   // body moves this edge
    output logic                               restart,
    output game_state_e                        state,
    output logic [SCORE_W-1:0]                 score,
    output logic                               food_valid,
    output logic                               eaten
);

    localparam int LEN_W = $clog2(MAX_LEN + 1);

    coord_t      food;          // food cell, only meaningful with food_valid
    game_state_e state_nxt;
    logic        run_step;      // step that actually plays
    logic        eat;           // next head lands on the food
    logic        room;          // body can still grow
    logic        tail_vacates;  // old tail cell frees up this step
    logic        hit;           // head runs into the body
    logic        eat_ok;        // food consumed this step

    //////////////////////////////////////////////////////////////////////
    // next head and collision
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_head = segs[0];
        case (dir)  // 5-bit arithmetic wraps around the grid
            DIR_RIGHT: next_head.x = segs[0].x + 1'b1;
            DIR_DOWN:  next_head.y = segs[0].y - 1'b1;
            DIR_LEFT:  next_head.x = segs[0].x - 1'b1;
            default:   next_head.y = segs[0].y + 1'b1;  // up
        endcase

        eat          = food_valid && (next_head == food);
        room         = (length < LEN_W'(MAX_LEN));
        tail_vacates = !(eat && room);

        hit = 1'b0;
        for (int i = 0; i < MAX_LEN; i++) begin
            // tail cell is free to enter when it moves away this step
            if (i < length && !(tail_vacates && i == length - 1)) begin
                if (segs[i] == next_head) begin
                    hit = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // body command, strobes to steering
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        run_step  = step && !start && (state == GAME_RUN);
        eat_ok    = run_step && eat && !hit;  // a fatal move eats nothing
        state_nxt = state;
        cmd       = BODY_HOLD;
        if (start) begin
            cmd       = BODY_CLEAR;  // start wins over step
            state_nxt = GAME_RUN;
        end else if (run_step) begin
            if (hit) begin
                state_nxt = GAME_DEAD;  // body frozen from here on
            end else if (eat && room) begin
                cmd = BODY_GROW;
            end else begin
                cmd = BODY_MOVE;        // incl. eating at full length
            end
        end
        advance = (cmd == BODY_MOVE) || (cmd == BODY_GROW);
        restart = start;
    end

    //////////////////////////////////////////////////////////////////////
    // state, score, food
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= GAME_IDLE;
            score      <= '0;
            food_valid <= 1'b0;
            eaten      <= 1'b0;
        end else begin
            state <= state_nxt;
            eaten <= eat_ok;  // one-cycle pulse
            if (start) begin
                score <= '0;
            end else if (eat_ok) begin
                score <= score + 1'b1;
            end
            if (food_load) begin
                food_valid <= 1'b1;  // fresh food beats a same-cycle eat
            end else if (eat_ok) begin
                food_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (food_load) begin
            food <= food_pos;
        end
    end

endmodule

`default_nettype wire

// File: rtl/snake_game.sv
`timescale 1ns/1ps
`default_nettype none

module snake_game import snake_pkg::*; #(
    parameter int MAX_LEN = 8  // body capacity incl. head
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        start,       // pulse
    input  wire logic                        step,        // pulse, one cell
    input  wire logic                        dir_strobe,  // pulse
    input  wire dir_e                        dir_req,
    input  wire logic                        food_load,   // pulse
    input  wire coord_t                      food_pos,
    output coord_t                           head,
    output coord_t [MAX_LEN-1:0]             segs,
    output logic   [$clog2(MAX_LEN+1)-1:0]   length,
    output logic   [SCORE_W-1:0]             score,
    output game_state_e                      state,
    output logic                             food_valid,
    output logic                             eaten
);

    dir_e      steer_dir;  // pending direction
    logic      advance;
    logic      restart;
    body_cmd_e body_cmd;
    coord_t    next_head;

    assign head = segs[0];

    //////////////////////////////////////////////////////////////////////
    // steering -> referee -> body
    //////////////////////////////////////////////////////////////////////

    snake_steer u_steer (
        .clk        (clk),
        .rst        (rst),
        .dir_strobe (dir_strobe),
        .dir_req    (dir_req),
        .advance    (advance),
        .restart    (restart),
        .dir        (steer_dir)
    );

    snake_referee #(.MAX_LEN(MAX_LEN)) u_referee (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .step       (step),
        .food_load  (food_load),
        .food_pos   (food_pos),
        .dir        (steer_dir),
        .segs       (segs),
        .length     (length),
        .cmd        (body_cmd),
        .next_head  (next_head),
        .advance    (advance),
        .restart    (restart),
        .state      (state),
        .score      (score),
        .food_valid (food_valid),
        .eaten      (eaten)
    );

    snake_body #(.MAX_LEN(MAX_LEN)) u_body (
        .clk        (clk),
        .rst        (rst),
        .cmd        (body_cmd),
        .next_head  (next_head),
        .segs       (segs),
        .length     (length)
    );

endmodule

`default_nettype wire

// File: bench/snake_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module snake_game_tb import snake_pkg::*; ();

    localparam int MAX_LEN = 8;
    localparam int LEN_W   = $clog2(MAX_LEN + 1);

    // one line of the case file
    typedef struct packed {
        logic [7:0] op;      // S T D F I
        logic [7:0] arg_a;
        logic [7:0] arg_b;
        logic [4:0] head_x;  // expected after the op
        logic [4:0] head_y;
        logic [7:0] len;
        logic [7:0] score;
        logic [1:0] state;
    } case_t;

    logic                       clk;
    logic                       rst;
    logic                       start;
    logic                       step;
    logic                       dir_strobe;
    dir_e                       dir_req;
    logic                       food_load;
    coord_t                     food_pos;
    coord_t                     head;
    coord_t [MAX_LEN-1:0]       segs;
    logic   [LEN_W-1:0]         length;
    logic   [SCORE_W-1:0]       score;
    game_state_e                state;
    logic                       food_valid;
    logic                       eaten;

    case_t cases[$];
    int    budget = 0;  // watchdog cycles, 0 until cases are loaded

    snake_game #(.MAX_LEN(MAX_LEN)) UUT (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .step       (step),
        .dir_strobe (dir_strobe),
        .dir_req    (dir_req),
        .food_load  (food_load),
        .food_pos   (food_pos),
        .head       (head),
        .segs       (segs),
        .length     (length),
        .score      (score),
        .state      (state),
        .food_valid (food_valid),
        .eaten      (eaten)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        int    op_c;
        int    a, b, hx, hy, ln, sc, st;
        string line;
        case_t c;
        fd = $fopen("bench/snake_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file bench/snake_cases.txt");
            $display("Regression failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip blank lines and the column notes
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %d %d %d %d %d %d %d",
                            op_c, a, b, hx, hy, ln, sc, st);
                if (n != 8) begin
                    $display("case file line has the wrong number of fields: %s", line);
                    $display("Regression failed");
                    $fatal(1, "bad case file");
                end
                c.op     = op_c[7:0];
                c.arg_a  = a[7:0];
                c.arg_b  = b[7:0];
                c.head_x = hx[4:0];
                c.head_y = hy[4:0];
                c.len    = ln[7:0];
                c.score  = sc[7:0];
                c.state  = st[1:0];
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // T and I repeat arg_a times, everything else is one pulse
    function automatic int op_reps(input case_t c);
        if ((c.op == "T" || c.op == "I") && c.arg_a > 1) begin
            return c.arg_a;
        end
        return 1;
    endfunction

    // drive on falling edges, strobes dropped one cycle later
    task automatic apply_case(input case_t c);
        repeat (op_reps(c)) begin
            @(negedge clk);
            case (c.op)
                "S": start = 1'b1;
                "T": step  = 1'b1;  // held high = back-to-back steps
                "D": begin
                    dir_strobe = 1'b1;
                    dir_req    = dir_e'(c.arg_a[1:0]);
                end
                "F": begin
                    food_load  = 1'b1;
                    food_pos.x = c.arg_a[4:0];
                    food_pos.y = c.arg_b[4:0];
                end
                "I": ;  // idle cycle
                default: begin
                    $display("unknown op code '%c' in the case file", c.op);
                    $display("Regression failed");
                    $fatal(1, "bad case file");
                end
            endcase
        end
        @(negedge clk);
        start      = 1'b0;
        step       = 1'b0;
        dir_strobe = 1'b0;
        food_load  = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        case_t                c;
        int                   total;
        logic                 exp_food;    // food_valid as the rules predict it
        logic                 eat_seen;
        logic [7:0]           prev_score;
        coord_t [MAX_LEN-1:0] exp_segs;    // body as the shift rule predicts it
        coord_t               exp_head;
        rst        = 1'b1;
        start      = 1'b0;
        step       = 1'b0;
        dir_strobe = 1'b0;
        dir_req    = DIR_RIGHT;
        food_load  = 1'b0;
        food_pos   = '0;
        exp_food   = 1'b0;
        prev_score = '0;
        exp_segs    = '0;
        exp_segs[0] = INIT_HEAD;  // lone head after reset

        load_cases();
        total = 4;  // reset cycles
        for (int i = 0; i < cases.size(); i++) begin
            total += op_reps(cases[i]) + 1;
        end
        budget = total * 4 + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < cases.size(); i++) begin
            c = cases[i];
            apply_case(c);  // returns on a falling edge, outputs settled
            if (c.op == "F") begin
                exp_food = 1'b1;
            end
            eat_seen = (c.op == "T") && (c.score != prev_score);  // score moved = eat
            if (eat_seen) begin
                exp_food = 1'b0;
            end

            // body model, one cell per moving line
            exp_head.x = c.head_x;
            exp_head.y = c.head_y;
            if (c.op == "S") begin
                exp_segs    = '0;
                exp_segs[0] = exp_head;
            end else if (exp_head != exp_segs[0]) begin
                for (int k = MAX_LEN - 1; k > 0; k--) begin
                    if (k < c.len) begin
                        exp_segs[k] = exp_segs[k-1];  // old cells slide tailward
                    end else begin
                        exp_segs[k] = '0;             // past the tail
                    end
                end
                exp_segs[0] = exp_head;
            end

            check_value(head.x, c.head_x, "head x");
            check_value(head.y, c.head_y, "head y");
            check_value(length, c.len, "length");
            check_value(score, c.score, "score");
            check_value(state, c.state, "state");
            check_value(food_valid, exp_food, "food_valid");
            check_value(eaten, eat_seen, "eaten");
            for (int k = 0; k < MAX_LEN; k++) begin
                check_value(segs[k], exp_segs[k], $sformatf("segment %0d", k));
            end
            prev_score = c.score;
        end

        $display("Regression passed");
        $finish;
    end

    // watchdog, armed once the case count is known
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("run timed out after %0d cycles without finishing the cases", budget);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: bench/snake_cases.txt
# op a b head_x head_y length score state
# S start, T step a times, D direction a, F food at (a,b), I idle a cycles
I 1 0 24 24 1 0 0
T 1 0 24 24 1 0 0
S 0 0 24 24 1 0 1
T 7 0 31 24 1 0 1
T 1 0 0 24 1 0 1
D 3 0 0 24 1 0 1
T 1 0 0 25 1 0 1
D 2 0 0 25 1 0 1
T 1 0 31 25 1 0 1
D 1 0 31 25 1 0 1
T 1 0 31 24 1 0 1
D 3 0 31 24 1 0 1
T 1 0 31 23 1 0 1
F 31 22 31 23 1 0 1
T 1 0 31 22 2 1 1
T 1 0 31 21 2 1 1
F 31 20 31 21 2 1 1
T 1 0 31 20 3 2 1
F 31 19 31 20 3 2 1
T 1 0 31 19 4 3 1
D 2 0 31 19 4 3 1
T 1 0 30 19 4 3 1
D 3 0 30 19 4 3 1
T 1 0 30 20 4 3 1
D 0 0 30 20 4 3 1
T 1 0 31 20 4 3 1
F 0 20 31 20 4 3 1
T 1 0 0 20 5 4 1
F 1 20 0 20 5 4 1
T 1 0 1 20 6 5 1
F 2 20 1 20 6 5 1
T 1 0 2 20 7 6 1
F 3 20 2 20 7 6 1
T 1 0 3 20 8 7 1
F 4 20 3 20 8 7 1
T 1 0 4 20 8 8 1
D 3 0 4 20 8 8 1
T 1 0 4 21 8 8 1
D 2 0 4 21 8 8 1
T 1 0 3 21 8 8 1
D 1 0 3 21 8 8 1
T 1 0 3 21 8 8 2
T 2 0 3 21 8 8 2
S 0 0 24 24 1 0 1

// File: verilog.f
rtl/snake_pkg.sv
rtl/snake_steer.sv
rtl/snake_body.sv
rtl/snake_referee.sv
rtl/snake_game.sv
bench/snake_game_tb.sv
